// File: softmax_pkg.sv
package softmax_pkg;

    // Bus and datapath widths
    localparam int ADDR_WIDTH = 24;
    localparam int WORD_BITS  = 32;
    localparam int ACTIV_BITS = 8;
    localparam int NUM_ELEMS  = 4;

    // Max weight sum is 4 x 128 = 512
    localparam int SUM_BITS = 10;

    // Top bits of an activation that pick the power-of-two weight
    localparam int EXP_BITS = 3;

    // Restoring divider runs one step per quotient bit of (w << 8) / sum
    localparam int DIV_STEPS = 2 * ACTIV_BITS;

    // Dummy sck cycles between address and read data
    localparam int READ_WAIT_CYCLES = 6;

    // PSRAM commands, always sent in QPI mode
    typedef enum logic [7:0] {
        CMD_QUAD_READ  = 8'hEB,
        CMD_QUAD_WRITE = 8'h38
    } psram_cmd_t;

    typedef enum logic [2:0] {
        PS_IDLE, PS_CMD, PS_ADDR, PS_WAIT, PS_DATA, PS_FINISH
    } psram_state_t;

    typedef enum logic [2:0] {
        JOB_IDLE, JOB_READ, JOB_COMPUTE, JOB_WRITE, JOB_DONE
    } job_state_t;

    typedef enum logic [1:0] {
        UNIT_IDLE, UNIT_SUM, UNIT_DIVIDE, UNIT_OUT
    } unit_state_t;

endpackage

// File: psram_qpi_ctrl.sv
`timescale 1ns/100ps

module psram_qpi_ctrl (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic [softmax_pkg::ADDR_WIDTH-1:0]  addr,
    input  logic [softmax_pkg::WORD_BITS-1:0]   data_i,
    output logic [softmax_pkg::WORD_BITS-1:0]   data_o,
    input  logic                                rd_wr,
    input  logic                                start,
    output logic                                done,
    output logic                                sck,
    output logic                                ce_n,
    input  logic [3:0]                          din,
    output logic [3:0]                          dout,
    output logic [3:0]                          douten
);
    import softmax_pkg::*;

    psram_state_t state;
    psram_cmd_t   cmd;
    logic         ph;
    logic [2:0]   cnt;
    logic         rd_q;
    logic         active;
    logic         nib_end;
    logic [4:0]   rd_off;

    // Command, address and write data, shifted out MSB nibble first
    logic [ADDR_WIDTH+WORD_BITS+7:0] tx_sr;

    assign cmd = rd_wr ? CMD_QUAD_READ : CMD_QUAD_WRITE;

    assign active = (state == PS_CMD) || (state == PS_ADDR) ||
                    (state == PS_WAIT) || (state == PS_DATA);

    // Second half of an sck period, where the next nibble is set up
    assign nib_end = active && ph;

    // Read nibble k lands in byte k/2, high nibble first
    assign rd_off = {cnt[2:1], ~cnt[0], 2'b00};

    assign dout = tx_sr[ADDR_WIDTH+WORD_BITS+7 -: 4];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state  <= PS_IDLE;
            ph     <= 1'b0;
            cnt    <= '0;
            rd_q   <= 1'b0;
            done   <= 1'b0;
            sck    <= 1'b0;
            ce_n   <= 1'b1;
            douten <= '0;
        end else begin
            done <= 1'b0;
            case (state)
                PS_IDLE: begin
                    if (start) begin
                        state  <= PS_CMD;
                        ph     <= 1'b0;
                        cnt    <= '0;
                        rd_q   <= rd_wr;
                        ce_n   <= 1'b0;
                        douten <= 4'hf;
                    end
                end
                PS_FINISH: begin
                    // Deselect gap before done
                    if (cnt == 3'd2) begin
                        done  <= 1'b1;
                        state <= PS_IDLE;
                    end else begin
                        cnt <= cnt + 3'd1;
                    end
                end
                default: begin
                    if (!ph) begin
                        sck <= 1'b1;
                        ph  <= 1'b1;
                    end else begin
                        sck <= 1'b0;
                        ph  <= 1'b0;
                        cnt <= cnt + 3'd1;
                        case (state)
                            PS_CMD: begin
                                if (cnt == 3'd1) begin
                                    state <= PS_ADDR;
                                    cnt   <= '0;
                                end
                            end
                            PS_ADDR: begin
                                if (cnt == 3'd5) begin
                                    cnt <= '0;
                                    if (rd_q) begin
                                        // Memory takes the bus after the address
                                        state  <= PS_WAIT;
                                        douten <= '0;
                                    end else begin
                                        state <= PS_DATA;
                                    end
                                end
                            end
                            PS_WAIT: begin
                                if (cnt == 3'(READ_WAIT_CYCLES - 1)) begin
                                    state <= PS_DATA;
                                    cnt   <= '0;
                                end
                            end
                            PS_DATA: begin
                                if (cnt == 3'd7) begin
                                    state  <= PS_FINISH;
                                    cnt    <= '0;
                                    ce_n   <= 1'b1;
                                    douten <= '0;
                                end
                            end
                            default: begin
                                state <= PS_IDLE;
                            end
                        endcase
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == PS_IDLE && start) begin
            tx_sr <= {cmd, addr, data_i[7:0], data_i[15:8], data_i[23:16], data_i[31:24]};
        end else if (nib_end) begin
            tx_sr <= {tx_sr[ADDR_WIDTH+WORD_BITS+3:0], 4'h0};
        end

        // Sample on the rising sck edge
        if (state == PS_DATA && rd_q && !ph) begin
            data_o[rd_off +: 4] <= din;
        end
    end

endmodule

// File: softmax_unit.sv
`timescale 1ns/100ps

module softmax_unit (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic                              in_valid,
    input  logic [softmax_pkg::WORD_BITS-1:0] in_data,
    output logic                              out_valid,
    output logic [softmax_pkg::WORD_BITS-1:0] out_data
);
    import softmax_pkg::*;

    localparam int ELEM_W = $clog2(NUM_ELEMS);
    localparam int STEP_W = $clog2(DIV_STEPS);

    unit_state_t             state;
    logic [ACTIV_BITS-1:0]   weight [NUM_ELEMS];
    logic [SUM_BITS-1:0]     weight_sum;
    logic [SUM_BITS-1:0]     sum_comb;
    logic [ELEM_W-1:0]       elem;
    logic [ELEM_W-1:0]       elem_nxt;
    logic [STEP_W-1:0]       step;
    logic                    last_step;

    // Restoring divider datapath
    logic [SUM_BITS-1:0]     rem;
    logic [DIV_STEPS-1:0]    quo;
    logic [SUM_BITS:0]       rem_shift;
    logic                    rem_ge;
    logic [SUM_BITS-1:0]     rem_next;
    logic [DIV_STEPS-1:0]    quo_next;

    always_comb begin
        sum_comb = '0;
        for (int i = 0; i < NUM_ELEMS; i++) begin
            sum_comb = sum_comb + SUM_BITS'(weight[i]);
        end
    end

    assign rem_shift = {rem, quo[DIV_STEPS-1]};
    assign rem_ge    = (rem_shift >= {1'b0, weight_sum});
    assign rem_next  = rem_ge ? SUM_BITS'(rem_shift - {1'b0, weight_sum})
                              : rem_shift[SUM_BITS-1:0];
    assign quo_next  = {quo[DIV_STEPS-2:0], rem_ge};

    assign elem_nxt  = elem + 1'b1;
    assign last_step = (step == STEP_W'(DIV_STEPS - 1));

    assign out_valid = (state == UNIT_OUT);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= UNIT_IDLE;
            elem  <= '0;
            step  <= '0;
        end else begin
            case (state)
                UNIT_IDLE: begin
                    if (in_valid) begin
                        state <= UNIT_SUM;
                    end
                end
                UNIT_SUM: begin
                    state <= UNIT_DIVIDE;
                    elem  <= '0;
                    step  <= '0;
                end
                UNIT_DIVIDE: begin
                    // Step counter wraps back to zero for the next element
                    step <= step + 1'b1;
                    if (last_step) begin
                        if (elem == ELEM_W'(NUM_ELEMS - 1)) begin
                            state <= UNIT_OUT;
                        end else begin
                            elem <= elem_nxt;
                        end
                    end
                end
                default: begin
                    state <= UNIT_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        case (state)
            UNIT_IDLE: begin
                // 2^(top bits), so weights run 1..128
                if (in_valid) begin
                    for (int i = 0; i < NUM_ELEMS; i++) begin
                        weight[i] <= ACTIV_BITS'(1) <<
                            in_data[i*ACTIV_BITS + ACTIV_BITS - EXP_BITS +: EXP_BITS];
                    end
                end
            end
            UNIT_SUM: begin
                weight_sum <= sum_comb;
                rem        <= '0;
                quo        <= {weight[0], {ACTIV_BITS{1'b0}}};
            end
            UNIT_DIVIDE: begin
                if (last_step) begin
                    // Quotient is always below 256
                    out_data[elem*ACTIV_BITS +: ACTIV_BITS] <= quo_next[ACTIV_BITS-1:0];
                    rem <= '0;
                    quo <= {weight[elem_nxt], {ACTIV_BITS{1'b0}}};
                end else begin
                    rem <= rem_next;
                    quo <= quo_next;
                end
            end
            default: begin
            end
        endcase
    end

endmodule

// File: softmax_psram.sv
`timescale 1ns/100ps

module softmax_psram (
    input  logic                               clk,
    input  logic                               rst_n,
    input  logic                               start,
    input  logic [softmax_pkg::ADDR_WIDTH-1:0] input_addr,
    input  logic [softmax_pkg::ADDR_WIDTH-1:0] output_addr,
    output logic                               done,
    output logic [softmax_pkg::ADDR_WIDTH-1:0] mem_addr,
    output logic [softmax_pkg::WORD_BITS-1:0]  mem_wdata,
    output logic                               mem_rd,
    output logic                               mem_start,
    input  logic [softmax_pkg::WORD_BITS-1:0]  mem_rdata,
    input  logic                               mem_done
);
    import softmax_pkg::*;

    job_state_t            state;
    logic [ADDR_WIDTH-1:0] in_addr_q;
    logic [ADDR_WIDTH-1:0] out_addr_q;
    logic                  unit_in_valid;
    logic                  unit_out_valid;
    logic [WORD_BITS-1:0]  unit_out_data;

    // Read data is held by the controller, so hand it over on its done
    assign unit_in_valid = (state == JOB_READ) && mem_done;

    assign mem_rd    = (state == JOB_READ);
    assign mem_addr  = (state == JOB_WRITE) ? out_addr_q : in_addr_q;
    assign mem_wdata = unit_out_data;
    assign done      = (state == JOB_DONE);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= JOB_IDLE;
            mem_start <= 1'b0;
        end else begin
            mem_start <= 1'b0;
            case (state)
                JOB_IDLE: begin
                    if (start) begin
                        state     <= JOB_READ;
                        mem_start <= 1'b1;
                    end
                end
                JOB_READ: begin
                    if (mem_done) begin
                        state <= JOB_COMPUTE;
                    end
                end
                JOB_COMPUTE: begin
                    if (unit_out_valid) begin
                        state     <= JOB_WRITE;
                        mem_start <= 1'b1;
                    end
                end
                JOB_WRITE: begin
                    if (mem_done) begin
                        state <= JOB_DONE;
                    end
                end
                default: begin
                    state <= JOB_IDLE;
                end
            endcase
        end
    end

    // Both addresses are taken at start, later start pulses are ignored
    always_ff @(posedge clk) begin
        if (state == JOB_IDLE && start) begin
            in_addr_q  <= input_addr;
            out_addr_q <= output_addr;
        end
    end

    softmax_unit u_unit (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (unit_in_valid),
        .in_data   (mem_rdata),
        .out_valid (unit_out_valid),
        .out_data  (unit_out_data)
    );

endmodule

// File: softmax_top.sv
`timescale 1ns/100ps

module softmax_psram_top (
    input  logic                               clk,
    input  logic                               rst_n,
    input  logic                               start,
    input  logic [softmax_pkg::ADDR_WIDTH-1:0] input_addr,
    input  logic [softmax_pkg::ADDR_WIDTH-1:0] output_addr,
    output logic                               done,
    output logic                               psram_sck,
    output logic                               psram_ce_n,
    inout  wire  [3:0]                         psram_d,
    output logic [3:0]                         psram_douten
);
    import softmax_pkg::*;

    logic [ADDR_WIDTH-1:0] mem_addr;
    logic [WORD_BITS-1:0]  mem_wdata;
    logic [WORD_BITS-1:0]  mem_rdata;
    logic                  mem_rd;
    logic                  mem_start;
    logic                  mem_done;
    logic [3:0]            ctrl_dout;
    logic [3:0]            ctrl_din;

    // Per-pin tristate, released whenever the memory owns the line
    for (genvar i = 0; i < 4; i++) begin : g_pin
        assign psram_d[i] = psram_douten[i] ? ctrl_dout[i] : 1'bz;
    end

    assign ctrl_din = psram_d;

    softmax_psram u_seq (
        .clk         (clk),
        .rst_n       (rst_n),
        .start       (start),
        .input_addr  (input_addr),
        .output_addr (output_addr),
        .done        (done),
        .mem_addr    (mem_addr),
        .mem_wdata   (mem_wdata),
        .mem_rd      (mem_rd),
        .mem_start   (mem_start),
        .mem_rdata   (mem_rdata),
        .mem_done    (mem_done)
    );

    psram_qpi_ctrl u_ctrl (
        .clk    (clk),
        .rst_n  (rst_n),
        .addr   (mem_addr),
        .data_i (mem_wdata),
        .data_o (mem_rdata),
        .rd_wr  (mem_rd),
        .start  (mem_start),
        .done   (mem_done),
        .sck    (psram_sck),
        .ce_n   (psram_ce_n),
        .din    (ctrl_din),
        .dout   (ctrl_dout),
        .douten (psram_douten)
    );

endmodule

// File: tb_psram_model.sv
`timescale 1ns/100ps

module tb_psram_model (
    input  logic       sck,
    input  logic       ce_n,
    inout  wire  [3:0] d
);
    import softmax_pkg::*;

    // Byte-wide storage, filled only where written
    logic [7:0]  mem [int unsigned];
    logic [7:0]  cmd;
    logic [23:0] addr;
    logic [3:0]  hi_nib;
    logic [3:0]  d_out;
    logic        d_oe;
    logic [7:0]  rd_byte;
    int          nib;
    int          k;

    assign d = d_oe ? d_out : 4'bz;

    initial begin
        d_oe  = 1'b0;
        d_out = 4'h0;
        nib   = 0;
    end

    // Unwritten bytes read back as a pattern of the full address
    function automatic logic [7:0] byte_at(input logic [23:0] a);
        if (mem.exists(a)) begin
            return mem[a];
        end
        return a[7:0] ^ a[15:8] ^ a[23:16] ^ 8'h5a;
    endfunction

    task automatic preload_word(input logic [23:0] a, input logic [31:0] w);
        for (int i = 0; i < 4; i++) begin
            mem[24'(a + i)] = w[i*8 +: 8];
        end
    endtask

    function automatic logic [31:0] peek_word(input logic [23:0] a);
        return {byte_at(24'(a + 3)), byte_at(24'(a + 2)), byte_at(24'(a + 1)), byte_at(a)};
    endfunction

    always @(negedge ce_n) begin
        nib = 0;
    end

    always @(posedge ce_n) begin
        d_oe = 1'b0;
    end

    // Command, address and write data are taken on the rising sck edge
    always @(posedge sck) begin
        if (ce_n === 1'b0) begin
            if (nib < 2) begin
                cmd = {cmd[3:0], d};
            end else if (nib < 8) begin
                addr = {addr[19:0], d};
            end else if (cmd == CMD_QUAD_WRITE && nib < 16) begin
                if (nib % 2 == 0) begin
                    hi_nib = d;
                end else begin
                    mem[24'(addr + (nib - 8) / 2)] = {hi_nib, d};
                end
            end
            nib = nib + 1;
        end
    end

    // Read nibbles set up on the falling edge, ahead of the next rise
    always @(negedge sck) begin
        if (ce_n === 1'b0 && cmd == CMD_QUAD_READ &&
            nib >= 8 + READ_WAIT_CYCLES && nib < 16 + READ_WAIT_CYCLES) begin
            k       = nib - 8 - READ_WAIT_CYCLES;
            rd_byte = byte_at(24'(addr + k / 2));
            d_out   = (k % 2 == 0) ? rd_byte[7:4] : rd_byte[3:0];
            d_oe    = 1'b1;
        end
    end

endmodule

// File: tb_softmax_monitor.sv
`timescale 1ns/100ps

module tb_softmax_monitor (
    input  logic clk,
    input  logic rst_n,
    input  logic done
);
    // Jobs announced by the sequence, in start order
    string       name_q [$];
    logic [31:0] word_q [$];
    logic [23:0] addr_q [$];
    string       cur_name;
    logic [31:0] cur_word;
    logic [23:0] cur_addr;
    int          n_pass = 0;
    int          n_fail = 0;
    int          n_done = 0;

    // Weight 2^(top three bits), output floor(w * 256 / sum)
    function automatic logic [31:0] softmax_ref(input logic [31:0] x);
        int          w [4];
        int          sum;
        logic [31:0] r;
        sum = 0;
        for (int i = 0; i < 4; i++) begin
            w[i] = 1 << x[i*8+5 +: 3];
            sum  = sum + w[i];
        end
        for (int i = 0; i < 4; i++) begin
            r[i*8 +: 8] = 8'((w[i] * 256) / sum);
        end
        return r;
    endfunction

    task automatic expect_job(input string name, input logic [31:0] word,
                              input logic [23:0] out_addr);
        name_q.push_back(name);
        word_q.push_back(word);
        addr_q.push_back(out_addr);
    endtask

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        if (exp === act) begin
            n_pass++;
            $display("[PASS] %s", name);
        end else begin
            n_fail++;
            $display("[FAIL] %s expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic note_failure(input string msg);
        n_fail++;
        $display("ERROR: %s", msg);
    endtask

    task automatic report_totals(input int assert_errors);
        if (name_q.size() != 0) begin
            note_failure("a started job never signalled done");
        end
        $display("Totals: %0d passed, %0d failed, %0d assertion failures",
                 n_pass, n_fail, assert_errors);
    endtask

    // Result is already in memory when done pulses
    always @(posedge clk) begin
        if (rst_n && done === 1'b1) begin
            n_done++;
            if (name_q.size() == 0) begin
                note_failure("done pulsed with no job pending");
            end else begin
                cur_name = name_q.pop_front();
                cur_word = word_q.pop_front();
                cur_addr = addr_q.pop_front();
                check_value(cur_name, softmax_ref(cur_word),
                            tb_softmax.u_mem.peek_word(cur_addr));
            end
        end
    end

endmodule

// File: softmax_chk.sv
`timescale 1ns/100ps

module softmax_chk (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       done,
    input  logic       psram_ce_n,
    input  logic [3:0] psram_douten
);
    int n_errors = 0;

    // Pins are driven only inside a selected transaction
    assert property (@(posedge clk) disable iff (!rst_n)
                     (psram_douten != 4'h0) |-> !psram_ce_n)
        else begin
            $error("douten set while ce_n is high");
            n_errors++;
        end

    assert property (@(posedge clk) disable iff (!rst_n) done |=> !done)
        else begin
            $error("done held longer than one cycle");
            n_errors++;
        end

    assert property (@(posedge clk) !rst_n |-> (psram_ce_n && !done))
        else begin
            $error("ce_n low or done high during reset");
            n_errors++;
        end

endmodule

// File: tb_softmax.sv
`timescale 1ns/100ps

module tb_softmax;
    import softmax_pkg::*;

    // 2 directed, 20 random, 1 busy and 3 chained jobs
    localparam int NUM_JOBS       = 26;
    localparam int CYCLES_PER_JOB = 200;

    logic                  clk;
    logic                  rst_n;
    logic                  start;
    logic [ADDR_WIDTH-1:0] input_addr;
    logic [ADDR_WIDTH-1:0] output_addr;
    logic                  done;
    logic                  psram_sck;
    logic                  psram_ce_n;
    wire  [3:0]            psram_d;
    logic [3:0]            psram_douten;
    int                    seed;
    logic [31:0]           word;
    logic [31:0]           chain [3];
    int                    idle_bad;
    int                    done_before;

    softmax_psram_top u_dut (
        .clk          (clk),
        .rst_n        (rst_n),
        .start        (start),
        .input_addr   (input_addr),
        .output_addr  (output_addr),
        .done         (done),
        .psram_sck    (psram_sck),
        .psram_ce_n   (psram_ce_n),
        .psram_d      (psram_d),
        .psram_douten (psram_douten)
    );

    tb_psram_model u_mem (
        .sck  (psram_sck),
        .ce_n (psram_ce_n),
        .d    (psram_d)
    );

    tb_softmax_monitor u_mon (
        .clk   (clk),
        .rst_n (rst_n),
        .done  (done)
    );

    bind softmax_psram_top softmax_chk u_chk (
        .clk          (clk),
        .rst_n        (rst_n),
        .done         (done),
        .psram_ce_n   (psram_ce_n),
        .psram_douten (psram_douten)
    );

    initial begin
        clk = 1'b0;
    end

    always begin
        #5 clk = ~clk;
    end

    task automatic wait_done();
        do begin
            @(posedge clk);
        end while (done !== 1'b1);
        #1;
    endtask

    task automatic run_job(input string name, input logic [31:0] w,
                           input logic [23:0] in_a, input logic [23:0] out_a);
        u_mem.preload_word(in_a, w);
        u_mon.expect_job(name, w, out_a);
        input_addr  = in_a;
        output_addr = out_a;
        start       = 1'b1;
        @(posedge clk);
        #1 start = 1'b0;
        wait_done();
    endtask

    initial begin
        repeat (NUM_JOBS * CYCLES_PER_JOB) @(posedge clk);
        $display("ERROR: timeout, the job sequence did not finish in time");
        $display("STATUS: FAIL");
        $finish;
    end

    initial begin
        seed        = 32'h6e55302a;
        rst_n       = 1'b1;
        start       = 1'b0;
        input_addr  = '0;
        output_addr = '0;
        idle_bad    = 0;
        // Falling reset edge ahead of the first clock
        #1 rst_n = 1'b0;
        repeat (3) @(posedge clk);
        #1 rst_n = 1'b1;

        // Pins stay idle without a start
        repeat (50) begin
            @(posedge clk);
            #1;
            if (done !== 1'b0 || psram_ce_n !== 1'b1 ||
                psram_douten !== 4'h0 || psram_sck !== 1'b0) begin
                idle_bad++;
            end
        end
        u_mon.check_value("idle_after_reset", 0, idle_bad);

        // All elements in the top-bit band 101
        run_job("equal_inputs", 32'ha5b0bfa0, 24'h000100, 24'h000200);
        run_job("one_dominant", 32'h0000ff00, 24'h000300, 24'h000400);

        for (int i = 0; i < 20; i++) begin
            word = $random(seed);
            run_job($sformatf("random_%0d", i), word, 24'h001000 + 24'(i * 8),
                    24'h002000 + 24'(i * 8));
        end

        // Held start, then a second pulse while the read is running
        word = $random(seed);
        u_mem.preload_word(24'h003000, word);
        u_mon.expect_job("busy_result", word, 24'h003100);
        done_before = u_mon.n_done;
        input_addr  = 24'h003000;
        output_addr = 24'h003100;
        start       = 1'b1;
        repeat (3) @(posedge clk);
        #1 start = 1'b0;
        repeat (10) @(posedge clk);
        #1 start = 1'b1;
        @(posedge clk);
        #1 start = 1'b0;
        wait_done();
        repeat (CYCLES_PER_JOB) @(posedge clk);
        #1;
        u_mon.check_value("busy_single_done", 1, u_mon.n_done - done_before);
        u_mon.check_value("busy_input_kept", word, u_mem.peek_word(24'h003000));

        for (int k = 0; k < 3; k++) begin
            chain[k] = $random(seed);
            run_job($sformatf("chain_%0d", k), chain[k], 24'h004000 + 24'(k * 4),
                    24'h004100);
        end
        u_mon.check_value("chain_last_result", u_mon.softmax_ref(chain[2]),
                          u_mem.peek_word(24'h004100));
        for (int k = 0; k < 3; k++) begin
            u_mon.check_value($sformatf("chain_input_kept_%0d", k), chain[k],
                              u_mem.peek_word(24'h004000 + 24'(k * 4)));
        end

        u_mon.report_totals(u_dut.u_chk.n_errors);
        if (u_mon.n_fail == 0 && u_dut.u_chk.n_errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

// File: project.f
softmax_pkg.sv
psram_qpi_ctrl.sv
softmax_unit.sv
softmax_psram.sv
softmax_top.sv
tb_psram_model.sv
tb_softmax_monitor.sv
softmax_chk.sv
tb_softmax.sv

// File: Bender.yml
package:
  name: softmax_psram

sources:
  - files:
      - softmax_pkg.sv
      - psram_qpi_ctrl.sv
      - softmax_unit.sv
      - softmax_psram.sv
      - softmax_top.sv
  - target: test
    files:
      - tb_psram_model.sv
      - tb_softmax_monitor.sv
      - softmax_chk.sv
      - tb_softmax.sv
